/* src/serial_cpu_macros.svh */
// width and start address constants of the serial byte-bus cpu core
`ifndef SERIAL_CPU_MACROS_SVH
`define SERIAL_CPU_MACROS_SVH

// --------------------
// data path widths
// --------------------
// general register and instruction width
`define SC_WORD_W 16
// one transfer on the instruction or data bus
`define SC_BYTE_W 8
// word address of the program counter
`define SC_PC_W 8

// --------------------
// register file and program start
// --------------------
`define SC_NUM_GR 4
// first program word, byte address 32
`define SC_DEFAULT_PC 16

`endif

/* src/serial_cpu_pkg.sv */
// shared data types, opcodes and state encoding of the serial cpu core
`include "serial_cpu_macros.svh"

package serial_cpu_pkg;

    // --------------------
    // vector types
    // --------------------
    typedef logic [`SC_WORD_W-1:0] word_t;
    typedef logic [`SC_BYTE_W-1:0] byte_t;
    typedef logic [`SC_PC_W-1:0] pc_t;
    // word address with the byte select bit appended
    typedef logic [`SC_PC_W:0] byte_addr_t;
    typedef logic [$clog2(`SC_NUM_GR)-1:0] reg_idx_t;

    // --------------------
    // instruction set
    // --------------------
    typedef enum logic [4:0] {
        NOP   = 5'd0,
        HALT  = 5'd1,
        LOAD  = 5'd2,
        STORE = 5'd3,
        LDIH  = 5'd4,
        ADD   = 5'd8,
        ADDI  = 5'd9,
        SUB   = 5'd10,
        SUBI  = 5'd11,
        CMP   = 5'd12,
        AND   = 5'd13,
        OR    = 5'd14,
        XOR   = 5'd15,
        SET   = 5'd16,
        LIOA  = 5'd20,
        LIOB  = 5'd21,
        LIOS  = 5'd22,
        JUMP  = 5'd24,
        JMPR  = 5'd25,
        BZ    = 5'd26,
        BNZ   = 5'd27,
        BN    = 5'd28,
        BNN   = 5'd29
    } opcode_e;

    // gray-like walk through the eight instruction states
    typedef enum logic [3:0] {
        IDLE = 4'b0000,
        IF   = 4'b0001,
        IF2  = 4'b0011,
        ID   = 4'b0010,
        EX   = 4'b0110,
        EX2  = 4'b0100,
        MEM  = 4'b0101,
        MEM2 = 4'b0111,
        WB   = 4'b1111
    } cpu_state_e;

    // f2 and f3 are register numbers or immediate nibbles
    typedef struct packed {
        opcode_e    op;
        logic [2:0] r1;
        logic [3:0] f2;
        logic [3:0] f3;
    } instr_t;

    typedef struct packed {
        logic zf;
        logic nf;
    } flags_t;

endpackage

/* src/serial_cpu_control.sv */
// state sequencer of the serial cpu with byte select and halt pulse
`timescale 1ns/1ns

module serial_cpu_control
    import serial_cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  opcode_e    op,
    input  pc_t        pc,
    output cpu_state_e state,
    output logic       lowest_bit,
    output logic       nxt
);

    cpu_state_e next_state;
    logic       last_word;

    // pc sits on the top word of program memory
    assign last_word = (pc == '1);

    // --------------------
    // state register
    // --------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= IDLE;
            lowest_bit <= 1'b0;
        end
        else
        begin
            state <= next_state;
            // odd byte in IF2, MEM and WB, even byte elsewhere
            lowest_bit <= (next_state == IF2) || (next_state == MEM) || (next_state == WB);
        end
    end

    // --------------------
    // next state
    // --------------------
    always_comb
    begin
        case (state)
            IDLE:    next_state = start ? IF : IDLE;
            IF:      next_state = IF2;
            IF2:     next_state = ID;
            ID:      next_state = EX;
            EX:      next_state = EX2;
            EX2:     next_state = MEM;
            MEM:     next_state = MEM2;
            MEM2:    next_state = WB;
            // run ends on halt or at the last word
            WB:      next_state = ((op == HALT) || last_word) ? IDLE : IF;
            default: next_state = IDLE;
        endcase
    end

    // single cycle done pulse while halt sits in WB
    assign nxt = (state == WB) && (op == HALT);

endmodule

/* src/serial_cpu_fetch.sv */
// instruction register assembly from two bus bytes and program counter update
`timescale 1ns/1ns
`include "serial_cpu_macros.svh"

module serial_cpu_fetch
    import serial_cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cpu_state_e state,
    input  byte_t      i_datain,
    input  logic       branch_taken,
    input  word_t      reg_c,
    output instr_t     ir,
    output pc_t        pc
);

    logic last_word;

    assign last_word = (pc == '1);

    // --------------------
    // instruction register
    // --------------------
    // low byte in IF, high byte in IF2
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ir <= '{op: NOP, default: '0};
        else if (state == IF)
            ir <= instr_t'({ir[`SC_WORD_W-1:`SC_BYTE_W], i_datain});
        else if (state == IF2)
            ir <= instr_t'({i_datain, ir[`SC_BYTE_W-1:0]});
    end

    // --------------------
    // program counter
    // --------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pc <= pc_t'(`SC_DEFAULT_PC);
        else if (state == WB)
        begin
            // taken branch wins over the wrap
            if (branch_taken)
                pc <= reg_c[`SC_PC_W-1:0];
            else if (last_word)
                pc <= pc_t'(`SC_DEFAULT_PC);
            else
                pc <= pc + 1'b1;
        end
    end

endmodule

/* src/serial_cpu_operands.sv */
// general register file with operand selection, store data and write-back
`timescale 1ns/1ns
`include "serial_cpu_macros.svh"

module serial_cpu_operands
    import serial_cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cpu_state_e state,
    input  instr_t     ir,
    input  word_t      reg_c,
    input  byte_t      d_datain,
    output word_t      reg_a,
    output word_t      reg_b,
    output word_t      smdr,
    output word_t      gr1,
    output word_t      gr2,
    output word_t      gr3
);

    word_t    gr [`SC_NUM_GR];
    reg_idx_t idx1;
    reg_idx_t idx2;
    reg_idx_t idx3;
    word_t    imm_lo;
    word_t    imm_hi;
    logic     writes_reg;

    // register numbers sit in the low bits of each field
    assign idx1 = ir.r1[1:0];
    assign idx2 = ir.f2[1:0];
    assign idx3 = ir.f3[1:0];

    // val2 and val3 as one byte, low or high half
    assign imm_lo = word_t'({ir.f2, ir.f3});
    assign imm_hi = {ir.f2, ir.f3, {`SC_BYTE_W{1'b0}}};

    // results that land in gr[r1] during WB
    assign writes_reg = ir.op inside {LDIH, ADD, ADDI, SUB, SUBI, AND, OR, XOR, SET,
                                      LIOA, LIOB, LIOS};

    // --------------------
    // operand read in ID
    // --------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            reg_a <= '0;
            reg_b <= '0;
            smdr  <= '0;
        end
        else if (state == ID)
        begin
            if (ir.op == STORE)
                smdr <= gr[idx1];

            // first alu operand
            case (ir.op)
                JUMP:
                    reg_a <= '0;
                LDIH, ADDI, SUBI, JMPR, BZ, BNZ, BN, BNN, SET:
                    reg_a <= gr[idx1];
                LOAD, STORE, ADD, SUB, CMP, AND, OR, XOR:
                    reg_a <= gr[idx2];
                default:
                    reg_a <= reg_a;
            endcase

            // second alu operand, immediate or register
            case (ir.op)
                LOAD, STORE:
                    reg_b <= word_t'(ir.f3);
                ADDI, SUBI, JUMP, JMPR, BZ, BNZ, BN, BNN, SET:
                    reg_b <= imm_lo;
                LDIH:
                    reg_b <= imm_hi;
                ADD, SUB, CMP, AND, OR, XOR:
                    reg_b <= gr[idx3];
                default:
                    reg_b <= reg_b;
            endcase
        end
    end

    // --------------------
    // write-back
    // --------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            gr <= '{default: '0};
        else if ((state == MEM2) && (ir.op == LOAD))
            // even byte first
            gr[idx1][`SC_BYTE_W-1:0] <= d_datain;
        else if (state == WB)
        begin
            if (ir.op == LOAD)
                gr[idx1][`SC_WORD_W-1:`SC_BYTE_W] <= d_datain;
            else if (writes_reg)
                gr[idx1] <= reg_c;
        end
    end

    // registers 1 to 3 go out on the io ports
    assign gr1 = gr[1];
    assign gr2 = gr[2];
    assign gr3 = gr[3];

endmodule

/* src/serial_cpu_execute.sv */
// alu, result register, flags, branch decision and data bus drive
`timescale 1ns/1ns
`include "serial_cpu_macros.svh"

module serial_cpu_execute
    import serial_cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cpu_state_e state,
    input  instr_t     ir,
    input  word_t      reg_a,
    input  word_t      reg_b,
    input  word_t      smdr,
    input  logic       lowest_bit,
    input  word_t      io_status,
    input  word_t      io_datain_a,
    input  word_t      io_datain_b,
    output word_t      reg_c,
    output logic       branch_taken,
    output byte_addr_t d_addr,
    output logic       d_we,
    output byte_t      d_dataout
);

    word_t  alu_out;
    flags_t flags;
    logic   flag_update;

    // --------------------
    // alu
    // --------------------
    always_comb
    begin
        case (ir.op)
            AND:            alu_out = reg_a & reg_b;
            OR:             alu_out = reg_a | reg_b;
            XOR:            alu_out = reg_a ^ reg_b;
            SET:            alu_out = reg_b;
            SUB, SUBI, CMP: alu_out = reg_a - reg_b;
            // also address and branch target sums
            default:        alu_out = reg_a + reg_b;
        endcase
    end

    // ops that touch zf and nf
    assign flag_update = ir.op inside {LDIH, ADD, ADDI, SUB, SUBI, CMP, AND, OR, XOR};

    // --------------------
    // result and flags in EX
    // --------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            reg_c <= '0;
            flags <= '0;
        end
        else if (state == EX)
        begin
            case (ir.op)
                LIOA:    reg_c <= io_datain_a;
                LIOB:    reg_c <= io_datain_b;
                LIOS:    reg_c <= io_status;
                default: reg_c <= alu_out;
            endcase

            if (flag_update)
            begin
                flags.zf <= (alu_out == '0);
                flags.nf <= alu_out[`SC_WORD_W-1];
            end
        end
    end

    // write strobe covers EX2 and MEM of a store
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            d_we <= 1'b0;
        else
            d_we <= ((state == EX) || (state == EX2)) && (ir.op == STORE);
    end

    // --------------------
    // branch decision
    // --------------------
    always_comb
    begin
        case (ir.op)
            JUMP, JMPR: branch_taken = 1'b1;
            BZ:         branch_taken = flags.zf;
            BNZ:        branch_taken = !flags.zf;
            BN:         branch_taken = flags.nf;
            BNN:        branch_taken = !flags.nf;
            default:    branch_taken = 1'b0;
        endcase
    end

    // data word address from reg_c, low byte at the even address
    assign d_addr    = {reg_c[`SC_PC_W-1:0], lowest_bit};
    assign d_dataout = lowest_bit ? smdr[`SC_WORD_W-1:`SC_BYTE_W] : smdr[`SC_BYTE_W-1:0];

endmodule

/* src/serial_cpu_top.sv */
// top level of the serial byte-bus cpu core joining the four units
`timescale 1ns/1ns

module serial_cpu_top
    import serial_cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  byte_t      i_datain,
    input  byte_t      d_datain,
    input  word_t      io_status,
    input  word_t      io_datain_a,
    input  word_t      io_datain_b,
    output logic       nxt,
    output byte_addr_t i_addr,
    output byte_addr_t d_addr,
    output logic       d_we,
    output byte_t      d_dataout,
    output word_t      io_control,
    output word_t      io_dataout_a,
    output word_t      io_dataout_b
);

    cpu_state_e state;
    logic       lowest_bit;
    instr_t     ir;
    pc_t        pc;
    word_t      reg_a;
    word_t      reg_b;
    word_t      smdr;
    word_t      reg_c;
    logic       branch_taken;

    // instruction byte address
    assign i_addr = {pc, lowest_bit};

    serial_cpu_control u_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .op         (ir.op),
        .pc         (pc),
        .state      (state),
        .lowest_bit (lowest_bit),
        .nxt        (nxt)
    );

    serial_cpu_fetch u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (state),
        .i_datain     (i_datain),
        .branch_taken (branch_taken),
        .reg_c        (reg_c),
        .ir           (ir),
        .pc           (pc)
    );

    // gr1 to gr3 drive the io outputs directly
    serial_cpu_operands u_operands (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (state),
        .ir       (ir),
        .reg_c    (reg_c),
        .d_datain (d_datain),
        .reg_a    (reg_a),
        .reg_b    (reg_b),
        .smdr     (smdr),
        .gr1      (io_control),
        .gr2      (io_dataout_a),
        .gr3      (io_dataout_b)
    );

    serial_cpu_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (state),
        .ir           (ir),
        .reg_a        (reg_a),
        .reg_b        (reg_b),
        .smdr         (smdr),
        .lowest_bit   (lowest_bit),
        .io_status    (io_status),
        .io_datain_a  (io_datain_a),
        .io_datain_b  (io_datain_b),
        .reg_c        (reg_c),
        .branch_taken (branch_taken),
        .d_addr       (d_addr),
        .d_we         (d_we),
        .d_dataout    (d_dataout)
    );

endmodule

/* tests/serial_cpu_tb.sv */
// self-checking testbench of the serial cpu core running programs from a stimulus file
`timescale 1ns/1ns
`include "serial_cpu_macros.svh"

module serial_cpu_tb
    import serial_cpu_pkg::*;
();

    localparam int RUN_TIMEOUT = 2000;
    localparam int STIM_DEPTH  = 256;
    localparam int MEM_BYTES   = 512;
    // first program byte, two bytes per word
    localparam int PROG_BASE   = 2 * `SC_DEFAULT_PC;

    logic       clk;
    logic       rst_n;
    logic       start;
    byte_t      i_datain;
    byte_t      d_datain;
    word_t      io_status;
    word_t      io_datain_a;
    word_t      io_datain_b;
    logic       nxt;
    byte_addr_t i_addr;
    byte_addr_t d_addr;
    logic       d_we;
    byte_t      d_dataout;
    word_t      io_control;
    word_t      io_dataout_a;
    word_t      io_dataout_b;

    byte_t imem [MEM_BYTES];
    byte_t dmem [MEM_BYTES];
    word_t stim [STIM_DEPTH];
    int    pos;
    word_t num_sections;

    serial_cpu_top i_serial_cpu_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .i_datain     (i_datain),
        .d_datain     (d_datain),
        .io_status    (io_status),
        .io_datain_a  (io_datain_a),
        .io_datain_b  (io_datain_b),
        .nxt          (nxt),
        .i_addr       (i_addr),
        .d_addr       (d_addr),
        .d_we         (d_we),
        .d_dataout    (d_dataout),
        .io_control   (io_control),
        .io_dataout_a (io_dataout_a),
        .io_dataout_b (io_dataout_b)
    );

    // 10 ns clock
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // memory models
    // --------------------
    // both memories answer in the same cycle
    assign i_datain = imem[i_addr];
    assign d_datain = dmem[d_addr];

    always @(posedge clk)
    begin
        if (d_we)
            dmem[d_addr] <= d_dataout;
    end

    // background bytes, all nine address bits mixed in
    function automatic byte_t fill_byte(input int addr);
        fill_byte = byte_t'((addr * 29) ^ (addr >> 8));
    endfunction

    // --------------------
    // reporting
    // --------------------
    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected)
        else
        begin
            $display("mismatch at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "simulation stopped");
        end
    endtask

    // next value of the stimulus file
    task automatic take_entry(output word_t value);
        assert ((pos < STIM_DEPTH) && !$isunknown(stim[pos]))
        else
            report_failure("stimulus file ended before the last section");
        value = stim[pos];
        pos++;
    endtask

    // reset held for 16 cycles, idle state checked afterwards
    task automatic reset_core();
        @(negedge clk);
        start = 1'b0;
        rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("nxt", '0, nxt);
        check_value("d_we", '0, d_we);
        check_value("i_addr", word_t'(PROG_BASE), i_addr);
        check_value("io_control", '0, io_control);
        check_value("io_dataout_a", '0, io_dataout_a);
        check_value("io_dataout_b", '0, io_dataout_b);
    endtask

    // --------------------
    // one program run
    // --------------------
    task automatic run_section(input int sec);
        word_t count;
        word_t value;
        word_t addr;
        word_t exp_control;
        word_t exp_a;
        word_t exp_b;
        word_t exp_instr;
        int    cycles;
        int    i;

        for (i = 0; i < MEM_BYTES; i++)
        begin
            imem[i] = fill_byte(i);
            dmem[i] <= fill_byte(i);
        end
        // program words, low byte first
        take_entry(count);
        for (i = 0; i < count; i++)
        begin
            take_entry(value);
            imem[PROG_BASE + 2 * i]     = value[7:0];
            imem[PROG_BASE + 2 * i + 1] = value[15:8];
        end
        take_entry(count);
        for (i = 0; i < count; i++)
        begin
            take_entry(addr);
            take_entry(value);
            dmem[addr[8:0]] <= value[7:0];
        end
        take_entry(value);
        io_status = value;
        take_entry(value);
        io_datain_a = value;
        take_entry(value);
        io_datain_b = value;
        take_entry(exp_control);
        take_entry(exp_a);
        take_entry(exp_b);
        take_entry(exp_instr);

        reset_core();

        // start seen by exactly one rising edge
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cycles = 1;
        while (!nxt && (cycles < RUN_TIMEOUT))
        begin
            @(negedge clk);
            cycles++;
        end
        assert (nxt === 1'b1)
        else
            report_failure($sformatf("no nxt pulse within %0d cycles in section %0d",
                                     RUN_TIMEOUT, sec));
        // eight states per instruction
        check_value($sformatf("nxt delay in section %0d", sec), exp_instr * 8, cycles);
        @(negedge clk);
        check_value($sformatf("nxt one cycle later in section %0d", sec), '0, nxt);

        check_value($sformatf("io_control in section %0d", sec), exp_control, io_control);
        check_value($sformatf("io_dataout_a in section %0d", sec), exp_a, io_dataout_a);
        check_value($sformatf("io_dataout_b in section %0d", sec), exp_b, io_dataout_b);

        take_entry(count);
        for (i = 0; i < count; i++)
        begin
            take_entry(addr);
            take_entry(value);
            check_value($sformatf("dmem[%03h] in section %0d", addr[8:0], sec),
                        value, dmem[addr[8:0]]);
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial
    begin
        rst_n       = 1'b0;
        start       = 1'b0;
        io_status   = '0;
        io_datain_a = '0;
        io_datain_b = '0;
        pos         = 0;
        $readmemh("tests/serial_cpu_stimulus.txt", stim);
        take_entry(num_sections);
        for (int sec = 0; sec < num_sections; sec++)
            run_section(sec);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* files.f */
+incdir+src
src/serial_cpu_pkg.sv
src/serial_cpu_control.sv
src/serial_cpu_fetch.sv
src/serial_cpu_operands.sv
src/serial_cpu_execute.sv
src/serial_cpu_top.sv
tests/serial_cpu_tb.sv

/* tests/serial_cpu_stimulus.txt */
// section: word count, words | data count, addr byte pairs | status in_a in_b,
// expected control out_a out_b, instruction count | checked count, addr byte pairs
0004
// arithmetic and logic
000a 8112 2234 4312 4905 5a01 5113 6b32 7221 7913 0800
0000
0000 0000 0000 fc17 ffff 3012 000a
0000
// store and load back, low byte at the even address
0009 81a5 213c 8240 1923 1323 1125 1921 1221 0800
0002 008a 0034 008b 0012
0000 0000 0000 1234 1234 3ca5 0009
0004 0082 0034 0083 0012 0086 00a5 0087 003c
// countdown loop, compare and branches, jump over corrupting sets
0014 8103 8200 4a02 5901 d812 6010 d018 83ee 6012 e820
e01c 83dd c01e 82cc 8320 cb02 81bb 82bb 4907 0800
0000
0000 0000 0000 0007 0006 0020 0015
0000
// io inputs into registers 1 to 3
0005 0000 a100 aa00 b300 0800
0000
5a5a beef 1357 beef 1357 5a5a 0005
0000
